// ==== logic/aes_pkg.sv ====
package aes_pkg;

  // AES-128 sizes
  localparam int NR             = 10;
  localparam int NK             = 4;
  localparam int NUM_ROUND_KEYS = NR + 1;

  typedef logic [7:0]   byte_t;
  typedef logic [31:0]  word_t;
  // byte 0 of a block is bits [127:120], columns are four bytes each
  typedef logic [127:0] block_t;
  typedef logic [127:0] key_t;
  typedef logic [3:0]   round_t;

  // one cipher request, decrypt high selects the inverse cipher
  typedef struct packed {
    logic   decrypt;
    key_t   key;
    block_t block;
  } aes_req_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXPAND,
    ST_INIT,
    ST_ROUND
  } ctrl_state_t;

endpackage

// ==== logic/aes_sbox.sv ====
`timescale 1ns/100ps

module aes_sbox #(
  parameter int INVERSE = 0
) (
  input  aes_pkg::byte_t in_byte,
  output aes_pkg::byte_t out_byte
);

  // product mod x^8 + x^4 + x^3 + x + 1
  function automatic aes_pkg::byte_t gf_mul(
    input aes_pkg::byte_t a,
    input aes_pkg::byte_t b
  );
    aes_pkg::byte_t acc;
    aes_pkg::byte_t sh;
    acc = '0;
    sh  = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
    end
    return acc;
  endfunction

  // x^254 through repeated squaring, zero stays zero
  function automatic aes_pkg::byte_t gf_inv(input aes_pkg::byte_t x);
    aes_pkg::byte_t sq;
    aes_pkg::byte_t acc;
    sq  = x;
    acc = 8'h01;
    for (int i = 1; i < 8; i++) begin
      sq  = gf_mul(sq, sq);
      acc = gf_mul(acc, sq);
    end
    return acc;
  endfunction

  function automatic aes_pkg::byte_t affine(input aes_pkg::byte_t b);
    aes_pkg::byte_t r;
    for (int i = 0; i < 8; i++) begin
      r[i] = b[i] ^ b[(i + 4) % 8] ^ b[(i + 5) % 8] ^ b[(i + 6) % 8] ^ b[(i + 7) % 8];
    end
    return r ^ 8'h63;
  endfunction

  function automatic aes_pkg::byte_t inv_affine(input aes_pkg::byte_t b);
    aes_pkg::byte_t r;
    for (int i = 0; i < 8; i++) begin
      r[i] = b[(i + 2) % 8] ^ b[(i + 5) % 8] ^ b[(i + 7) % 8];
    end
    return r ^ 8'h05;
  endfunction

  if (INVERSE != 0) begin : g_inv
    assign out_byte = gf_inv(inv_affine(in_byte));
  end else begin : g_fwd
    assign out_byte = affine(gf_inv(in_byte));
  end

endmodule

// ==== logic/aes_top.sv ====
`timescale 1ns/100ps

module aes_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  aes_pkg::aes_req_t req,
  output logic              busy,
  output logic              done,
  output aes_pkg::block_t   result
);

  logic            key_load;
  logic            keys_ready;
  logic            last_round;
  aes_pkg::key_t   key;
  aes_pkg::round_t key_idx;
  aes_pkg::block_t round_key;
  aes_pkg::block_t state;
  aes_pkg::block_t enc_next;
  aes_pkg::block_t dec_next;

  round_ctrl i_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .req        (req),
    .keys_ready (keys_ready),
    .round_key  (round_key),
    .enc_next   (enc_next),
    .dec_next   (dec_next),
    .key_load   (key_load),
    .key        (key),
    .key_idx    (key_idx),
    .state      (state),
    .last_round (last_round),
    .busy       (busy),
    .done       (done),
    .result     (result)
  );

  key_schedule i_keys (
    .clk        (clk),
    .rst_n      (rst_n),
    .key_load   (key_load),
    .key        (key),
    .key_idx    (key_idx),
    .round_key  (round_key),
    .keys_ready (keys_ready)
  );

  // both units see the same state, the controller picks one
  enc_round i_enc (
    .state      (state),
    .round_key  (round_key),
    .last_round (last_round),
    .next_state (enc_next)
  );

  dec_round i_dec (
    .state      (state),
    .round_key  (round_key),
    .last_round (last_round),
    .next_state (dec_next)
  );

endmodule

// ==== logic/dec_round.sv ====
`timescale 1ns/100ps

module dec_round (
  input  aes_pkg::block_t state,
  input  aes_pkg::block_t round_key,
  input  logic            last_round,
  output aes_pkg::block_t next_state
);

  aes_pkg::block_t shift_out;
  aes_pkg::block_t sub_out;
  aes_pkg::block_t add_out;
  aes_pkg::block_t mix_out;

  // field product with a constant of up to four bits
  function automatic aes_pkg::byte_t gf_mul_c(
    input aes_pkg::byte_t b,
    input logic [3:0]     m
  );
    aes_pkg::byte_t acc;
    aes_pkg::byte_t sh;
    acc = '0;
    sh  = b;
    for (int i = 0; i < 4; i++) begin
      if (m[i]) begin
        acc = acc ^ sh;
      end
      sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
    end
    return acc;
  endfunction

  // row r moves right by r columns
  for (genvar c = 0; c < 4; c++) begin : g_shift
    for (genvar r = 0; r < 4; r++) begin : g_row
      assign shift_out[127 - 8*(4*c + r) -: 8] =
          state[127 - 8*(4*((c - r + 4) % 4) + r) -: 8];
    end
  end

  for (genvar n = 0; n < 16; n++) begin : g_sub
    aes_sbox #(.INVERSE(1)) i_sbox (
      .in_byte  (shift_out[127 - 8*n -: 8]),
      .out_byte (sub_out[127 - 8*n -: 8])
    );
  end

  assign add_out = sub_out ^ round_key;

  // circulant 14 11 13 9 per column
  for (genvar c = 0; c < 4; c++) begin : g_mix
    aes_pkg::word_t col;
    assign col = add_out[127 - 32*c -: 32];
    for (genvar r = 0; r < 4; r++) begin : g_row
      assign mix_out[127 - 32*c - 8*r -: 8] =
          gf_mul_c(col[31 - 8*r -: 8], 4'd14)
        ^ gf_mul_c(col[31 - 8*((r + 1) % 4) -: 8], 4'd11)
        ^ gf_mul_c(col[31 - 8*((r + 2) % 4) -: 8], 4'd13)
        ^ gf_mul_c(col[31 - 8*((r + 3) % 4) -: 8], 4'd9);
    end
  end

  // last round ends on the key add
  assign next_state = last_round ? add_out : mix_out;

endmodule

// ==== logic/enc_round.sv ====
`timescale 1ns/100ps

module enc_round (
  input  aes_pkg::block_t state,
  input  aes_pkg::block_t round_key,
  input  logic            last_round,
  output aes_pkg::block_t next_state
);

  aes_pkg::block_t sub_out;
  aes_pkg::block_t shift_out;
  aes_pkg::block_t mix_out;

  // multiply by x in the field
  function automatic aes_pkg::byte_t xtime(input aes_pkg::byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  for (genvar n = 0; n < 16; n++) begin : g_sub
    aes_sbox #(.INVERSE(0)) i_sbox (
      .in_byte  (state[127 - 8*n -: 8]),
      .out_byte (sub_out[127 - 8*n -: 8])
    );
  end

  // row r moves left by r columns
  for (genvar c = 0; c < 4; c++) begin : g_shift
    for (genvar r = 0; r < 4; r++) begin : g_row
      assign shift_out[127 - 8*(4*c + r) -: 8] =
          sub_out[127 - 8*(4*((c + r) % 4) + r) -: 8];
    end
  end

  // circulant 2 3 1 1 per column
  for (genvar c = 0; c < 4; c++) begin : g_mix
    aes_pkg::word_t col;
    assign col = shift_out[127 - 32*c -: 32];
    for (genvar r = 0; r < 4; r++) begin : g_row
      assign mix_out[127 - 32*c - 8*r -: 8] =
          xtime(col[31 - 8*r -: 8])
        ^ xtime(col[31 - 8*((r + 1) % 4) -: 8])
        ^ col[31 - 8*((r + 1) % 4) -: 8]
        ^ col[31 - 8*((r + 2) % 4) -: 8]
        ^ col[31 - 8*((r + 3) % 4) -: 8];
    end
  end

  // final round has no MixColumns
  assign next_state = (last_round ? shift_out : mix_out) ^ round_key;

endmodule

// ==== logic/key_schedule.sv ====
`timescale 1ns/100ps

module key_schedule (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            key_load,
  input  aes_pkg::key_t   key,
  input  aes_pkg::round_t key_idx,
  output aes_pkg::block_t round_key,
  output logic            keys_ready
);

  aes_pkg::block_t rk_mem [aes_pkg::NUM_ROUND_KEYS];
  aes_pkg::block_t prev_key;
  aes_pkg::block_t next_key;
  aes_pkg::word_t  rot_word;
  aes_pkg::word_t  sub_word;
  aes_pkg::round_t gen_idx;
  logic            gen_active;

  function automatic aes_pkg::byte_t rcon(input aes_pkg::round_t r);
    case (r)
      4'd1:    return 8'h01;
      4'd2:    return 8'h02;
      4'd3:    return 8'h04;
      4'd4:    return 8'h08;
      4'd5:    return 8'h10;
      4'd6:    return 8'h20;
      4'd7:    return 8'h40;
      4'd8:    return 8'h80;
      4'd9:    return 8'h1b;
      4'd10:   return 8'h36;
      default: return 8'h00;
    endcase
  endfunction

  // rotate last word of previous key
  assign rot_word = {prev_key[23:0], prev_key[31:24]};

  for (genvar i = 0; i < 4; i++) begin : g_sub
    aes_sbox #(.INVERSE(0)) i_sbox (
      .in_byte  (rot_word[8*i +: 8]),
      .out_byte (sub_word[8*i +: 8])
    );
  end

  // each word chains on the one before it
  always_comb begin
    aes_pkg::word_t acc;
    acc = sub_word ^ {rcon(gen_idx), 24'h000000};
    for (int i = 0; i < aes_pkg::NK; i++) begin
      acc = acc ^ prev_key[127 - 32*i -: 32];
      next_key[127 - 32*i -: 32] = acc;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gen_idx    <= '0;
      gen_active <= 1'b0;
      keys_ready <= 1'b0;
    end else begin
      keys_ready <= 1'b0;
      if (key_load) begin
        gen_idx    <= 4'd1;
        gen_active <= 1'b1;
      end else if (gen_active) begin
        gen_idx <= gen_idx + 4'd1;
        if (gen_idx == aes_pkg::round_t'(aes_pkg::NR)) begin
          gen_active <= 1'b0;
          keys_ready <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (key_load) begin
      rk_mem[0] <= key;
      prev_key  <= key;
    end else if (gen_active) begin
      rk_mem[gen_idx] <= next_key;
      prev_key        <= next_key;
    end
  end

  assign round_key = rk_mem[key_idx];

endmodule

// ==== logic/round_ctrl.sv ====
`timescale 1ns/100ps

module round_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  aes_pkg::aes_req_t req,
  input  logic              keys_ready,
  input  aes_pkg::block_t   round_key,
  input  aes_pkg::block_t   enc_next,
  input  aes_pkg::block_t   dec_next,
  output logic              key_load,
  output aes_pkg::key_t     key,
  output aes_pkg::round_t   key_idx,
  output aes_pkg::block_t   state,
  output logic              last_round,
  output logic              busy,
  output logic              done,
  output aes_pkg::block_t   result
);

  aes_pkg::ctrl_state_t st_q;
  aes_pkg::aes_req_t    req_q;
  aes_pkg::round_t      rnd_q;
  aes_pkg::block_t      next_blk;
  logic                 idle;

  assign idle     = (st_q == aes_pkg::ST_IDLE);
  assign busy     = !idle;
  assign key_load = idle && start;
  // key reaches the schedule on the accepting edge
  assign key      = idle ? req.key : req_q.key;
  // decryption walks the keys downward
  assign key_idx    = req_q.decrypt ? aes_pkg::round_t'(aes_pkg::NR - rnd_q) : rnd_q;
  assign last_round = (rnd_q == aes_pkg::round_t'(aes_pkg::NR));
  assign next_blk   = req_q.decrypt ? dec_next : enc_next;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      st_q   <= aes_pkg::ST_IDLE;
      rnd_q  <= '0;
      done   <= 1'b0;
      result <= '0;
    end else begin
      done <= 1'b0;
      case (st_q)
        aes_pkg::ST_IDLE: begin
          if (start) begin
            st_q  <= aes_pkg::ST_EXPAND;
            rnd_q <= 4'd1;
          end
        end
        // tracks the schedule, one key per cycle
        aes_pkg::ST_EXPAND: begin
          if (last_round) begin
            st_q  <= aes_pkg::ST_INIT;
            rnd_q <= '0;
          end else begin
            rnd_q <= rnd_q + 4'd1;
          end
        end
        aes_pkg::ST_INIT: begin
          if (keys_ready) begin
            st_q  <= aes_pkg::ST_ROUND;
            rnd_q <= 4'd1;
          end
        end
        aes_pkg::ST_ROUND: begin
          if (last_round) begin
            st_q   <= aes_pkg::ST_IDLE;
            result <= next_blk;
            done   <= 1'b1;
          end else begin
            rnd_q <= rnd_q + 4'd1;
          end
        end
        default: st_q <= aes_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (key_load) begin
      req_q <= req;
    end
    // initial whitening, then one round per edge
    if (st_q == aes_pkg::ST_INIT && keys_ready) begin
      state <= req_q.block ^ round_key;
    end else if (st_q == aes_pkg::ST_ROUND && !last_round) begin
      state <= next_blk;
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module aes_tb -f src.f -o aes_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/aes_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== src.f ====
+incdir+test
logic/aes_pkg.sv
logic/aes_sbox.sv
logic/key_schedule.sv
logic/enc_round.sv
logic/dec_round.sv
logic/round_ctrl.sv
logic/aes_top.sv
test/clk_gen.sv
test/aes_sva.sv
test/aes_tb.sv

// ==== test/aes_sva.sv ====
`timescale 1ns/100ps

module aes_sva (
  input logic            clk,
  input logic            rst_n,
  input logic            start,
  input logic            busy,
  input logic            done,
  input aes_pkg::block_t result
);

  done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done stayed high for more than one cycle");

  done_idle: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
    else $error("done seen while busy was high");

  start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (start && !busy) |=> busy)
    else $error("start while idle did not raise busy");

  // result only moves on the done cycle
  result_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !done |-> $stable(result))
    else $error("result changed outside done");

endmodule

bind aes_top aes_sva i_sva (
  .clk    (clk),
  .rst_n  (rst_n),
  .start  (start),
  .busy   (busy),
  .done   (done),
  .result (result)
);

// ==== test/aes_model.svh ====
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

aes_pkg::byte_t  sbox_tbl [256];
aes_pkg::byte_t  inv_sbox_tbl [256];
aes_pkg::block_t model_rk [aes_pkg::NUM_ROUND_KEYS];

function automatic aes_pkg::byte_t gmul(input aes_pkg::byte_t a, input aes_pkg::byte_t b);
  aes_pkg::byte_t p;
  aes_pkg::byte_t x;
  aes_pkg::byte_t y;
  p = 8'h00;
  x = a;
  y = b;
  while (y != 8'h00) begin
    if (y[0]) begin
      p = p ^ x;
    end
    x = (x << 1) ^ (x[7] ? 8'h1b : 8'h00);
    y = y >> 1;
  end
  return p;
endfunction

// walk the field with generator 3 and its inverse 0xf6
task automatic build_sbox_tables();
  aes_pkg::byte_t p;
  aes_pkg::byte_t q;
  aes_pkg::byte_t x;
  p = 8'h01;
  q = 8'h01;
  repeat (255) begin
    p = gmul(p, 8'h03);
    q = gmul(q, 8'hf6);
    x = q ^ {q[6:0], q[7]} ^ {q[5:0], q[7:6]} ^ {q[4:0], q[7:5]} ^ {q[3:0], q[7:4]} ^ 8'h63;
    sbox_tbl[p]     = x;
    inv_sbox_tbl[x] = p;
  end
  sbox_tbl[0]         = 8'h63;
  inv_sbox_tbl[8'h63] = 8'h00;
endtask

function automatic void model_expand(input aes_pkg::key_t key);
  aes_pkg::word_t w [aes_pkg::NK * (aes_pkg::NR + 1)];
  aes_pkg::word_t t;
  aes_pkg::byte_t rc;
  rc = 8'h01;
  for (int i = 0; i < aes_pkg::NK; i++) begin
    w[i] = key[127 - 32*i -: 32];
  end
  for (int i = aes_pkg::NK; i < aes_pkg::NK * (aes_pkg::NR + 1); i++) begin
    t = w[i-1];
    if (i % aes_pkg::NK == 0) begin
      t = {sbox_tbl[t[23:16]], sbox_tbl[t[15:8]], sbox_tbl[t[7:0]], sbox_tbl[t[31:24]]}
        ^ {rc, 24'h000000};
      rc = gmul(rc, 8'h02);
    end
    w[i] = w[i-aes_pkg::NK] ^ t;
  end
  for (int r = 0; r < aes_pkg::NUM_ROUND_KEYS; r++) begin
    model_rk[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
  end
endfunction

// SubBytes and ShiftRows commute, so both happen in one pass
function automatic aes_pkg::block_t sub_shift(input aes_pkg::block_t b, input bit inv);
  aes_pkg::block_t o;
  int              src;
  for (int n = 0; n < 16; n++) begin
    if (inv) begin
      src = 4 * (((n / 4) - (n % 4) + 4) % 4) + n % 4;
    end else begin
      src = 4 * (((n / 4) + (n % 4)) % 4) + n % 4;
    end
    o[127 - 8*n -: 8] = inv ? inv_sbox_tbl[b[127 - 8*src -: 8]]
                            : sbox_tbl[b[127 - 8*src -: 8]];
  end
  return o;
endfunction

function automatic aes_pkg::block_t mix(input aes_pkg::block_t b, input bit inv);
  aes_pkg::block_t o;
  aes_pkg::byte_t  m [4];
  aes_pkg::byte_t  acc;
  if (inv) begin
    m = '{8'h0e, 8'h0b, 8'h0d, 8'h09};
  end else begin
    m = '{8'h02, 8'h03, 8'h01, 8'h01};
  end
  for (int c = 0; c < 4; c++) begin
    for (int r = 0; r < 4; r++) begin
      acc = 8'h00;
      for (int k = 0; k < 4; k++) begin
        acc = acc ^ gmul(m[(k - r + 4) % 4], b[127 - 32*c - 8*k -: 8]);
      end
      o[127 - 32*c - 8*r -: 8] = acc;
    end
  end
  return o;
endfunction

function automatic aes_pkg::block_t model_cipher(input aes_pkg::aes_req_t r);
  aes_pkg::block_t s;
  model_expand(r.key);
  if (!r.decrypt) begin
    s = r.block ^ model_rk[0];
    for (int n = 1; n <= aes_pkg::NR; n++) begin
      s = sub_shift(s, 1'b0);
      if (n < aes_pkg::NR) begin
        s = mix(s, 1'b0);
      end
      s = s ^ model_rk[n];
    end
  end else begin
    s = r.block ^ model_rk[aes_pkg::NR];
    for (int n = aes_pkg::NR - 1; n >= 0; n--) begin
      s = sub_shift(s, 1'b1) ^ model_rk[n];
      if (n > 0) begin
        s = mix(s, 1'b1);
      end
    end
  end
  return s;
endfunction

`endif

// ==== test/aes_tb.sv ====
`timescale 1ns/100ps

module aes_tb;

  localparam int NUM_RANDOM     = 40;
  // known vectors, random requests, round trips, ignored-start run
  localparam int MAX_REQUESTS   = 2 + 2 * NUM_RANDOM + 1;
  localparam int TIMEOUT_CYCLES = MAX_REQUESTS * 25 + 100;
  localparam int LATENCY        = 2 * aes_pkg::NR + 1;

  logic              clk;
  logic              rst_n;
  logic              start;
  aes_pkg::aes_req_t req;
  logic              busy;
  logic              done;
  aes_pkg::block_t   result;

  integer seed;
  int     cycle_cnt = 0;

  `include "aes_model.svh"

  clk_gen i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  aes_top i_dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .req    (req),
    .busy   (busy),
    .done   (done),
    .result (result)
  );

  task automatic stop_with_fail();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_block(input string name, input aes_pkg::block_t exp,
                             input aes_pkg::block_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      stop_with_fail();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      stop_with_fail();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
      stop_with_fail();
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout: the DUT never finished, %0d cycles elapsed", cycle_cnt);
      stop_with_fail();
    end
  end

  // stray_at >= 0 pulses start with another request that many cycles in
  task automatic run_request(input string name, input aes_pkg::aes_req_t r,
                             input int stray_at, input aes_pkg::aes_req_t stray,
                             output aes_pkg::block_t res);
    int lat;
    @(posedge clk);
    #1;
    req   = r;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    lat   = 0;
    while (!done) begin
      check_flag({name, " busy"}, 1'b1, busy);
      if (lat == stray_at) begin
        req   = stray;
        start = 1'b1;
      end else begin
        start = 1'b0;
      end
      @(posedge clk);
      #1;
      lat++;
    end
    start = 1'b0;
    check_count({name, " latency"}, LATENCY, lat);
    check_flag({name, " busy at done"}, 1'b0, busy);
    res = result;
  endtask

  function automatic aes_pkg::block_t rand_block();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  initial begin
    aes_pkg::aes_req_t r;
    aes_pkg::aes_req_t back;
    aes_pkg::block_t   res;
    aes_pkg::block_t   res2;
    logic [31:0]       rnd;
    string             name;
    seed  = 19;
    start = 1'b0;
    req   = '0;
    build_sbox_tables();

    repeat (3) @(posedge clk);
    #1;
    check_flag("in reset busy", 1'b0, busy);
    check_flag("in reset done", 1'b0, done);
    check_block("in reset result", '0, result);
    wait (rst_n === 1'b1);
    @(posedge clk);
    #1;
    check_flag("after reset busy", 1'b0, busy);
    check_flag("after reset done", 1'b0, done);
    check_block("after reset result", '0, result);

    // FIPS-197 appendix C.1
    r.decrypt = 1'b0;
    r.key     = 128'h000102030405060708090a0b0c0d0e0f;
    r.block   = 128'h00112233445566778899aabbccddeeff;
    check_block("model vector", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, model_cipher(r));
    run_request("vector encrypt", r, -1, r, res);
    check_block("vector encrypt", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, res);
    r.decrypt = 1'b1;
    r.block   = res;
    run_request("vector decrypt", r, -1, r, res);
    check_block("vector decrypt", 128'h00112233445566778899aabbccddeeff, res);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      rnd       = $random(seed);
      r.decrypt = rnd[0];
      r.key     = rand_block();
      r.block   = rand_block();
      name      = $sformatf("random %0d", i);
      run_request(name, r, -1, r, res);
      check_block(name, model_cipher(r), res);
      if (!r.decrypt) begin
        back         = r;
        back.decrypt = 1'b1;
        back.block   = res;
        name         = $sformatf("round trip %0d", i);
        run_request(name, back, -1, back, res2);
        check_block(name, r.block, res2);
      end
    end

    // second start while busy must not disturb the first request
    r.decrypt    = 1'b0;
    r.key        = rand_block();
    r.block      = rand_block();
    back.decrypt = 1'b1;
    back.key     = ~r.key;
    back.block   = rand_block();
    run_request("ignored start", r, 5, back, res);
    check_block("ignored start", model_cipher(r), res);
    @(posedge clk);
    #1;
    check_flag("ignored start stays idle", 1'b0, busy);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== test/clk_gen.sv ====
`timescale 1ns/100ps

module clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reset held for 8 rising edges
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule
